/* Makefile */
TOP = lbm_streamer_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
		--top-module $(TOP) -Mdir obj_dir -f src.f

run: compile
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee /dev/stderr | \
		grep -x "RESULT: PASS" > /dev/null

clean:
	rm -rf obj_dir

/* common/lbm_ctrl_pkg.sv */
package lbm_ctrl_pkg;

    // One distribution value
    typedef logic signed [15:0] sample_t;

    // Sweep phases
    typedef enum logic [2:0]
    {
        ph_init,    // Fill current bank once after reset
        ph_idle,    // Waits for go, serves read-outs
        ph_clear,   // Zero the next bank
        ph_stream,  // Move values to neighbours, one drain cycle
        ph_scrub,   // Zero barrier cells of next bank
        ph_swap     // Next bank becomes current
    } phase_t;

    // Bank select
    typedef logic bank_t;

endpackage

/* common/lbm_geom_pkg.sv */
package lbm_geom_pkg;

    localparam int num_dirs = 9;

    // D2Q9 directions, rest first and then clockwise from north
    typedef enum logic [3:0]
    {
        d_rest,
        d_n,
        d_ne,
        d_e,
        d_se,
        d_s,
        d_sw,
        d_w,
        d_nw
    } dir_t;

    // Column step, east positive
    function automatic int dir_dx(dir_t d);
        case (d)
            d_ne, d_e, d_se: return 1;
            d_nw, d_w, d_sw: return -1;
            default:         return 0;
        endcase
    endfunction

    // Row step, north is row minus one
    function automatic int dir_dy(dir_t d);
        case (d)
            d_nw, d_n, d_ne: return -1;
            d_sw, d_s, d_se: return 1;
            default:         return 0;
        endcase
    endfunction

    // Direction pointing straight back
    function automatic dir_t dir_opposite(dir_t d);
        return (d == d_rest) ? d_rest : dir_t'((int'(d) + 3) % 8 + 1);
    endfunction

endpackage

/* dist_mem/dist_bank.sv */
module dist_bank
    import lbm_ctrl_pkg::*;
    import lbm_geom_pkg::*;
#(
    parameter int lattice_width  = 8,
    parameter int lattice_height = 6,
    parameter int addr_width     = 6
)
(
    input  logic                  clk,
    input  logic [addr_width-1:0] read_addr,
    input  bank_t                 cur_bank,
    input  bank_t                 wr_bank,
    input  logic [num_dirs-1:0]   wr_en,
    input  logic [addr_width-1:0] wr_addr [num_dirs],
    input  sample_t               wr_data [num_dirs],
    output sample_t               q_dist [num_dirs]
);

    localparam int num_cells = lattice_width * lattice_height;

    ////////////////////////////////////////
    // One memory per direction, both banks

    for (genvar g = 0; g < num_dirs; g++)
    begin : g_dir
        sample_t mem [2][num_cells];   // Bank, then cell

        // Independent write port per direction
        always_ff @(posedge clk)
        begin
            if (wr_en[g])
            begin
                mem[wr_bank][wr_addr[g]] <= wr_data[g];
            end
        end

        // Registered read from the current bank
        always_ff @(posedge clk)
        begin
            q_dist[g] <= mem[cur_bank][read_addr];
        end
    end

endmodule

/* src.f */
common/lbm_ctrl_pkg.sv
common/lbm_geom_pkg.sv
src/sweep_sequencer.sv
src/neighbor_map.sv
src/stream_writer.sv
dist_mem/dist_bank.sv
src/lbm_streamer.sv
test/lbm_streamer_assert.sv
test/lbm_streamer_tb.sv

/* src/lbm_streamer.sv */
module lbm_streamer
    import lbm_ctrl_pkg::*;
    import lbm_geom_pkg::*;
#(
    parameter int  lattice_width  = 8,
    parameter int  lattice_height = 6,
    localparam int num_cells      = lattice_width * lattice_height,
    // One spare code so the stream index can sit one past the last cell
    localparam int addr_width     = $clog2(num_cells + 1)
)
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  go,
    input  logic [15:0]           step_count_in,
    input  logic [num_cells-1:0]  barriers,
    input  sample_t               init_dist [num_dirs],
    input  logic                  rd_strobe,
    input  logic [addr_width-1:0] rd_addr,
    output logic                  busy,
    output logic                  done,
    output logic [15:0]           step_count,
    output logic                  rd_valid,
    output sample_t               rd_dist [num_dirs]
);

    ////////////////////////////////////////
    // Internal wiring

    phase_t                phase;
    logic [addr_width-1:0] index;
    logic [addr_width-1:0] read_addr;
    bank_t                 cur_bank;
    bank_t                 wr_bank;
    logic                  blocked;
    logic                  src_ok;       // Aligned with bank read data
    logic [addr_width-1:0] target_addr [num_dirs];
    logic [num_dirs-1:0]   wr_en;
    logic [addr_width-1:0] wr_addr [num_dirs];
    sample_t               wr_data [num_dirs];

    ////////////////////////////////////////
    // Blocks

    sweep_sequencer #(
        .lattice_width  (lattice_width),
        .lattice_height (lattice_height),
        .addr_width     (addr_width)
    ) i_sweep_sequencer (
        .clk            (clk),
        .rst            (rst),
        .go             (go),
        .step_count_in  (step_count_in),
        .rd_strobe      (rd_strobe),
        .rd_addr        (rd_addr),
        .phase          (phase),
        .index          (index),
        .read_addr      (read_addr),
        .cur_bank       (cur_bank),
        .busy           (busy),
        .done           (done),
        .step_count     (step_count),
        .rd_valid       (rd_valid)
    );

    // Bank output feeds both the writer and the read-out port
    dist_bank #(
        .lattice_width  (lattice_width),
        .lattice_height (lattice_height),
        .addr_width     (addr_width)
    ) i_dist_bank (
        .clk            (clk),
        .read_addr      (read_addr),
        .cur_bank       (cur_bank),
        .wr_bank        (wr_bank),
        .wr_en          (wr_en),
        .wr_addr        (wr_addr),
        .wr_data        (wr_data),
        .q_dist         (rd_dist)
    );

    neighbor_map #(
        .lattice_width  (lattice_width),
        .lattice_height (lattice_height),
        .addr_width     (addr_width)
    ) i_neighbor_map (
        .clk            (clk),
        .rst            (rst),
        .index          (index),
        .barriers       (barriers),
        .blocked        (blocked),
        .src_ok         (src_ok),
        .target_addr    (target_addr)
    );

    stream_writer #(
        .lattice_width  (lattice_width),
        .lattice_height (lattice_height),
        .addr_width     (addr_width)
    ) i_stream_writer (
        .phase          (phase),
        .index          (index),
        .cur_bank       (cur_bank),
        .init_dist      (init_dist),
        .blocked        (blocked),
        .src_ok         (src_ok),
        .target_addr    (target_addr),
        .q_dist         (rd_dist),
        .wr_en          (wr_en),
        .wr_addr        (wr_addr),
        .wr_data        (wr_data),
        .wr_bank        (wr_bank)
    );

endmodule

/* src/neighbor_map.sv */
module neighbor_map
    import lbm_geom_pkg::*;
#(
    parameter int  lattice_width  = 8,
    parameter int  lattice_height = 6,
    parameter int  addr_width     = 6,
    localparam int num_cells      = lattice_width * lattice_height
)
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [addr_width-1:0] index,
    input  logic [num_cells-1:0]  barriers,
    output logic                  blocked,
    output logic                  src_ok,
    output logic [addr_width-1:0] target_addr [num_dirs]
);

    int   col;
    int   row;
    logic interior;   // Not on the outer ring

    assign col = int'(index) % lattice_width;
    assign row = int'(index) / lattice_width;

    assign interior = (col > 0) && (col < lattice_width - 1) &&
                      (row > 0) && (row < lattice_height - 1);

    // Drain index lies past the grid and counts as open
    assign blocked = (int'(index) < num_cells) ? barriers[index] : 1'b0;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            src_ok <= 1'b0;
        else
            src_ok <= interior && !blocked;   // Lines up with q_dist
    end

    ////////////////////////////////////////
    // Neighbour addresses, one per direction

    always_ff @(posedge clk)
    begin
        for (int d = 0; d < num_dirs; d++)
        begin
            target_addr[d] <= addr_width'(int'(index)
                                          + dir_dy(dir_t'(d)) * lattice_width
                                          + dir_dx(dir_t'(d)));
        end
    end

endmodule

/* src/stream_writer.sv */
module stream_writer
    import lbm_ctrl_pkg::*;
    import lbm_geom_pkg::*;
#(
    parameter int lattice_width  = 8,
    parameter int lattice_height = 6,
    parameter int addr_width     = 6
)
(
    input  phase_t                phase,
    input  logic [addr_width-1:0] index,
    input  bank_t                 cur_bank,
    input  sample_t               init_dist [num_dirs],
    input  logic                  blocked,
    input  logic                  src_ok,
    input  logic [addr_width-1:0] target_addr [num_dirs],
    input  sample_t               q_dist [num_dirs],
    output logic [num_dirs-1:0]   wr_en,
    output logic [addr_width-1:0] wr_addr [num_dirs],
    output sample_t               wr_data [num_dirs],
    output bank_t                 wr_bank
);

    localparam int num_cells = lattice_width * lattice_height;

    logic stream_live;   // Bank data of cell index-1 is present

    // First stream cycle still carries the read of the clear phase
    assign stream_live = (index != '0) && (int'(index) <= num_cells);

    // Only init touches the current bank
    assign wr_bank = (phase == ph_init) ? cur_bank : ~cur_bank;

    always_comb
    begin
        for (int d = 0; d < num_dirs; d++)
        begin
            wr_en[d]   = 1'b0;
            wr_addr[d] = index;
            wr_data[d] = '0;

            case (phase)
                ph_init:
                begin
                    wr_en[d]   = 1'b1;
                    wr_data[d] = blocked ? sample_t'(0) : init_dist[d];
                end
                ph_clear:
                begin
                    wr_en[d] = 1'b1;   // Zero data
                end
                ph_stream:
                begin
                    wr_en[d]   = src_ok && stream_live;
                    wr_addr[d] = target_addr[d];
                    wr_data[d] = q_dist[d];
                end
                ph_scrub:
                begin
                    wr_en[d] = blocked;   // Barrier cells only
                end
                default:
                begin
                    wr_en[d] = 1'b0;
                end
            endcase
        end
    end

endmodule

/* src/sweep_sequencer.sv */
module sweep_sequencer
    import lbm_ctrl_pkg::*;
#(
    parameter int lattice_width  = 8,
    parameter int lattice_height = 6,
    parameter int addr_width     = 6
)
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  go,
    input  logic [15:0]           step_count_in,
    input  logic                  rd_strobe,
    input  logic [addr_width-1:0] rd_addr,
    output phase_t                phase,
    output logic [addr_width-1:0] index,
    output logic [addr_width-1:0] read_addr,
    output bank_t                 cur_bank,
    output logic                  busy,
    output logic                  done,
    output logic [15:0]           step_count,
    output logic                  rd_valid
);

    localparam int num_cells = lattice_width * lattice_height;

    localparam logic [addr_width-1:0] last_cell  = addr_width'(num_cells - 1);
    localparam logic [addr_width-1:0] drain_cell = addr_width'(num_cells);  // Stream only

    logic [15:0] steps_left;   // Steps still to run in this go
    logic        sweep_end;    // Last cycle of the running phase

    assign busy = (phase != ph_idle);

    // Bank read port follows the sweep, or the outside in idle
    assign read_addr = busy ? index : rd_addr;

    assign sweep_end = (phase == ph_stream) ? (index == drain_cell) : (index == last_cell);

    ////////////////////////////////////////
    // Phase machine

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            phase      <= ph_init;
            index      <= '0;
            cur_bank   <= 1'b0;
            steps_left <= '0;
            step_count <= '0;
            done       <= 1'b0;
            rd_valid   <= 1'b0;
        end
        else
        begin
            done     <= 1'b0;
            rd_valid <= rd_strobe && !busy;   // Data is on q_dist next cycle

            case (phase)
                ph_idle:
                begin
                    if (go)
                    begin
                        steps_left <= step_count_in;
                        index      <= '0;
                        if (step_count_in == 16'd0)
                            done <= 1'b1;   // Nothing to run
                        else
                            phase <= ph_clear;
                    end
                end

                ph_init, ph_clear, ph_stream, ph_scrub:
                begin
                    // One cell per cycle
                    if (sweep_end)
                    begin
                        index <= '0;
                        case (phase)
                            ph_init:   phase <= ph_idle;
                            ph_clear:  phase <= ph_stream;
                            ph_stream: phase <= ph_scrub;
                            default:   phase <= ph_swap;
                        endcase
                    end
                    else
                    begin
                        index <= index + 1'b1;
                    end
                end

                ph_swap:
                begin
                    cur_bank   <= ~cur_bank;
                    step_count <= step_count + 16'd1;
                    steps_left <= steps_left - 16'd1;
                    if (steps_left == 16'd1)
                    begin
                        phase <= ph_idle;
                        done  <= 1'b1;   // Falls together with busy
                    end
                    else
                    begin
                        phase <= ph_clear;
                    end
                end

                default:
                begin
                    phase <= ph_idle;
                end
            endcase
        end
    end

endmodule

/* test/lbm_streamer_assert.sv */
module lbm_streamer_assert
    import lbm_ctrl_pkg::*;
#(
    parameter int lattice_width  = 8,
    parameter int lattice_height = 6
)
(
    input logic        clk,
    input logic        rst,
    input logic        go,
    input logic [15:0] step_count_in,
    input logic        rd_strobe,
    input logic        busy,
    input logic        done,
    input logic        rd_valid,
    input phase_t      phase
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int step_cycles = 3 * lattice_width * lattice_height + 2;

    int unsigned failures = 0;
    logic        run_armed;    // Go taken with done still ahead
    logic [31:0] run_left;     // Cycles until done is due
    logic        read_taken;   // Strobe accepted last cycle

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            run_armed  <= 1'b0;
            run_left   <= '0;
            read_taken <= 1'b0;
        end
        else
        begin
            read_taken <= rd_strobe && (phase == ph_idle);
            if (go && !busy)
            begin
                run_armed <= 1'b1;
                run_left  <= 32'(step_count_in) * step_cycles;
            end
            else if (run_armed)
            begin
                if (run_left == 0)
                    run_armed <= 1'b0;
                else
                    run_left <= run_left - 1;
            end
        end
    end

    ////////////////////////////////////////
    // Go to done

    assert property (@(posedge clk) disable iff (!rst)
        go && !busy && step_count_in != 16'd0 |=> $rose(busy))
    else begin failures++; $error("busy did not rise after an accepted go"); end

    assert property (@(posedge clk) disable iff (!rst)
        run_armed && run_left == 0 |-> done && !busy)
    else begin failures++; $error("done missing at k steps after the busy rise"); end

    assert property (@(posedge clk) disable iff (!rst)
        done |-> run_armed && run_left == 0)
    else begin failures++; $error("done pulsed at an unexpected cycle"); end

    ////////////////////////////////////////
    // Read-out and reset values

    assert property (@(posedge clk) disable iff (!rst) rd_valid == read_taken)
    else begin failures++; $error("rd_valid does not follow an idle read strobe"); end

    assert property (@(posedge clk) !rst || phase == ph_init |-> !done && !rd_valid)
    else begin failures++; $error("done or rd_valid high during reset or init"); end

endmodule

bind lbm_streamer lbm_streamer_assert #(
    .lattice_width  (lattice_width),
    .lattice_height (lattice_height)
) i_lbm_streamer_assert (
    .clk            (clk),
    .rst            (rst),
    .go             (go),
    .step_count_in  (step_count_in),
    .rd_strobe      (rd_strobe),
    .busy           (busy),
    .done           (done),
    .rd_valid       (rd_valid),
    .phase          (phase)
);

/* test/lbm_streamer_tb.sv */
module lbm_streamer_tb
    import lbm_ctrl_pkg::*;
    import lbm_geom_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int lattice_width  = 8;
    localparam int lattice_height = 6;
    localparam int num_cells      = lattice_width * lattice_height;
    localparam int addr_width     = $clog2(num_cells + 1);
    localparam int reset_cycles   = 16;
    localparam int step_cycles    = 3 * num_cells + 2;
    localparam int total_steps    = 5;
    localparam int total_reads    = 5;   // Full lattice read-outs
    localparam int cycle_limit    = 2 * (reset_cycles + num_cells) + total_steps * step_cycles
                                    + total_reads * 2 * num_cells + 100;

    // Offsets with rest first and then clockwise from north
    localparam int step_x [num_dirs] = '{0, 0, 1, 1, 1, 0, -1, -1, -1};
    localparam int step_y [num_dirs] = '{0, -1, -1, 0, 1, 1, 1, 0, -1};

    logic                  clk;
    logic                  rst;
    logic                  go;
    logic [15:0]           step_count_in;
    logic [num_cells-1:0]  barriers;
    sample_t               init_dist [num_dirs];
    logic                  rd_strobe;
    logic [addr_width-1:0] rd_addr;
    logic                  busy;
    logic                  done;
    logic [15:0]           step_count;
    logic                  rd_valid;
    sample_t               rd_dist [num_dirs];

    sample_t     ref_lat [num_cells][num_dirs];   // Reference lattice
    logic [15:0] exp_step_count;                  // Steps completed since reset
    logic [31:0] rng;
    int          checks;
    int          errors;
    int          cycles;

    lbm_streamer #(
        .lattice_width  (lattice_width),
        .lattice_height (lattice_height)
    ) i_lbm_streamer (
        .clk            (clk),
        .rst            (rst),
        .go             (go),
        .step_count_in  (step_count_in),
        .barriers       (barriers),
        .init_dist      (init_dist),
        .rd_strobe      (rd_strobe),
        .rd_addr        (rd_addr),
        .busy           (busy),
        .done           (done),
        .step_count     (step_count),
        .rd_valid       (rd_valid),
        .rd_dist        (rd_dist)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////////////////////////
    // Helpers

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Short wall in column 3 plus two single cells
    function automatic logic [num_cells-1:0] wall_map();
        logic [num_cells-1:0] map;
        map = '0;
        for (int r = 1; r <= 3; r++)
            map[r * lattice_width + 3] = 1'b1;
        map[4 * lattice_width + 6] = 1'b1;
        map[0] = 1'b1;
        return map;
    endfunction

    task automatic draw_random_map(output logic [num_cells-1:0] map);
        for (int c = 0; c < num_cells; c++)
        begin
            rng    = next_random(rng);
            map[c] = (rng[3:0] < 4'd4);   // About one cell in four
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #5;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        assert (got === expected)
        else
        begin
            errors++;
            $display("Fail %s: got %h expected %h", name, got, expected);
        end
    endtask

    task automatic check_flag(input logic ok, input string what);
        checks++;
        assert (ok)
        else
        begin
            errors++;
            $display("%s", what);
        end
    endtask

    ////////////////////////////////////////
    // Reference lattice

    task automatic load_reference();
        for (int c = 0; c < num_cells; c++)
            for (int d = 0; d < num_dirs; d++)
                ref_lat[c][d] = barriers[c] ? sample_t'(0) : init_dist[d];
    endtask

    task automatic advance_reference();
        sample_t nxt [num_cells][num_dirs];
        int      col;
        int      row;
        int      dst;
        for (int c = 0; c < num_cells; c++)
            for (int d = 0; d < num_dirs; d++)
                nxt[c][d] = '0;
        for (int c = 0; c < num_cells; c++)
        begin
            col = c % lattice_width;
            row = c / lattice_width;
            if (!barriers[c] && col > 0 && col < lattice_width - 1 &&
                row > 0 && row < lattice_height - 1)
            begin
                for (int d = 0; d < num_dirs; d++)
                begin
                    dst = (row + step_y[d]) * lattice_width + col + step_x[d];
                    nxt[dst][d] = ref_lat[c][d];
                end
            end
        end
        for (int c = 0; c < num_cells; c++)
            for (int d = 0; d < num_dirs; d++)
                ref_lat[c][d] = barriers[c] ? sample_t'(0) : nxt[c][d];
    endtask

    ////////////////////////////////////////
    // Stimulus

    task automatic apply_reset(input logic [num_cells-1:0] map);
        int waited;
        rst            = 1'b0;
        barriers       = map;
        exp_step_count = '0;
        repeat (reset_cycles) next_cycle();
        rst    = 1'b1;
        waited = 0;
        while (busy && waited < num_cells + 4)
        begin
            check_flag(!done && !rd_valid, "done or rd_valid went high during init");
            next_cycle();
            waited++;
        end
        check_value("busy length of init", waited, num_cells);
    endtask

    // Optionally pokes go and rd_strobe while the run is busy
    task automatic run_steps(input int k, input logic poke);
        int waited;
        go            = 1'b1;
        step_count_in = 16'(k);
        next_cycle();
        go            = 1'b0;
        step_count_in = '0;
        waited        = 1;
        while (!done && waited <= k * step_cycles + 4)
        begin
            check_flag(busy && !rd_valid, "busy low or rd_valid high during a run");
            if (poke && waited == 10)
            begin
                go            = 1'b1;
                step_count_in = 16'd5;
                rd_strobe     = 1'b1;
                rd_addr       = addr_width'(2);
            end
            else
            begin
                go        = 1'b0;
                rd_strobe = 1'b0;
            end
            next_cycle();
            waited++;
        end
        go             = 1'b0;
        rd_strobe      = 1'b0;
        exp_step_count = exp_step_count + 16'(k);
        check_flag(done, "done never arrived after go");
        check_value("done latency", waited, 1 + k * step_cycles);
        check_flag(!busy, "busy still high in the done cycle");
        check_value("step_count", step_count, exp_step_count);
    endtask

    task automatic check_lattice();
        int waited;
        for (int c = 0; c < num_cells; c++)
        begin
            rd_strobe = 1'b1;
            rd_addr   = addr_width'(c);
            next_cycle();
            rd_strobe = 1'b0;
            waited    = 0;
            while (!rd_valid && waited < 4)
            begin
                next_cycle();
                waited++;
            end
            check_flag(rd_valid, $sformatf("No read data came back for cell %0d", c));
            for (int d = 0; d < num_dirs; d++)
                check_value($sformatf("rd_dist[%0d] of cell %0d", d, c),
                            rd_dist[d], ref_lat[c][d]);
        end
    endtask

    ////////////////////////////////////////
    // Test sequence

    initial
    begin
        logic [num_cells-1:0] rand_map;
        rng            = 32'd25339;
        rst            = 1'b0;
        go             = 1'b0;
        step_count_in  = '0;
        rd_strobe      = 1'b0;
        rd_addr        = '0;
        barriers       = '0;
        exp_step_count = '0;
        checks         = 0;
        errors         = 0;
        for (int d = 0; d < num_dirs; d++)
        begin
            rng          = next_random(rng);
            init_dist[d] = sample_t'(rng[15:0]);
        end

        apply_reset(wall_map());   // Fixed map with init and then one step
        load_reference();
        check_lattice();
        run_steps(1, 1'b0);
        advance_reference();
        check_lattice();

        draw_random_map(rand_map);
        apply_reset(rand_map);
        load_reference();
        run_steps(3, 1'b0);
        repeat (3) advance_reference();
        check_lattice();

        run_steps(1, 1'b1);        // Go and read strobe while busy
        advance_reference();
        check_lattice();

        run_steps(0, 1'b0);        // Lattice stays as it was
        check_lattice();

        $display("Checks %0d, errors %0d, assertion failures %0d", checks, errors,
                 i_lbm_streamer.i_lbm_streamer_assert.failures);
        if (errors == 0 && i_lbm_streamer.i_lbm_streamer_assert.failures == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

    // Watchdog
    initial
    begin
        cycles = 0;
        while (cycles < cycle_limit)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the test sequence did not finish", cycles);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule
